// ==== logic/tap_settings.svh ====
//----------------------------------------------------------------------
// sizing constants for the stream tap, shared by the package and RTL
// include this wherever lane count or word layout is needed
//----------------------------------------------------------------------
`ifndef TAP_SETTINGS_SVH
`define TAP_SETTINGS_SVH

// number of condition-mirror lanes chained on the main stream
`define TAP_NUM_LANES 4

// width of one stream word
`define TAP_WORD_W 32

// the tag lives in the top byte of each word
`define TAP_TAG_H 31
`define TAP_TAG_L 24

`endif

// ==== logic/tap_pkg.sv ====
//----------------------------------------------------------------------
// types shared by the stream tap RTL and its testbench
// import with a wildcard in the module header
//----------------------------------------------------------------------
`include "tap_settings.svh"

package tap_pkg;

    typedef logic [`TAP_WORD_W-1:0]              word_t;      // one stream word
    typedef logic [`TAP_TAG_H-`TAP_TAG_L:0]      tag_t;       // tag byte of a word
    typedef logic [$clog2(`TAP_NUM_LANES)-1:0]   lane_idx_t;  // lane number

    // record on the merged mirror output, lane index sits above the word
    typedef struct packed {
        lane_idx_t lane;
        word_t     word;
    } mirror_rec_t;

    // pull the tag field out of a word
    function automatic tag_t tag_of(input word_t w);
        return w[`TAP_TAG_H:`TAP_TAG_L];
    endfunction

endpackage

// ==== logic/stream_if.sv ====
//----------------------------------------------------------------------
// valid/ready stream bundle used between the tap's internal blocks
// the payload type is a parameter so words and mirror records share it
//----------------------------------------------------------------------
`timescale 1ns/1ps

interface stream_if import tap_pkg::*; #(
    parameter type T = word_t               // payload carried per beat
) (
    input logic clock,
    input logic rst_n
);

    logic valid;                            // source has a beat on data
    logic ready;                            // sink takes the beat this edge
    T     data;

    // the producing side of a link
    modport source (
        input  clock,
        input  rst_n,
        input  ready,
        output valid,
        output data
    );

    // the consuming side of a link
    modport sink (
        input  clock,
        input  rst_n,
        output ready,
        input  valid,
        input  data
    );

endinterface

// ==== logic/pipe_stage.sv ====
//----------------------------------------------------------------------
// two-entry skid slice with a registered ready toward the source
// used for ingress and for every internal stage of the lanes
//----------------------------------------------------------------------
`timescale 1ns/1ps

module pipe_stage import tap_pkg::*; #(
    parameter type T = word_t
) (
    input  logic     clock,
    input  logic     rst_n,
    stream_if.sink   up,
    stream_if.source dn
);

    logic out_valid_r;      // output register holds a beat
    T     out_data_r;
    logic skid_valid_r;     // second entry holds a beat caught while dn stalled
    T     skid_data_r;
    logic ready_r;          // registered ready, low during reset
    logic up_fire;
    logic out_free;         // output register can be loaded this edge
    logic skid_valid_nxt;

    assign up_fire  = up.valid && ready_r;
    assign out_free = !out_valid_r || dn.ready;

    // the skid entry fills only when a beat arrives while the output is stuck
    always_comb begin
        if (skid_valid_r) begin
            skid_valid_nxt = !out_free;
        end else begin
            skid_valid_nxt = up_fire && !out_free;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            out_valid_r  <= 1'b0;
            skid_valid_r <= 1'b0;
            ready_r      <= 1'b0;   // comes up one cycle after reset release
        end else begin
            if (out_free) begin
                out_valid_r <= skid_valid_r || up_fire;
            end
            skid_valid_r <= skid_valid_nxt;
            ready_r      <= !skid_valid_nxt;    // accept again once the skid is empty
        end
    end

    // payload path, the skid entry drains before any new beat
    always_ff @(posedge clock) begin
        if (out_free) begin
            out_data_r <= skid_valid_r ? skid_data_r : up.data;
        end
        if (up_fire && !out_free) begin
            skid_data_r <= up.data;
        end
    end

    assign up.ready = ready_r;
    assign dn.valid = out_valid_r;
    assign dn.data  = out_data_r;

endmodule

// ==== logic/condition_mirror.sv ====
//----------------------------------------------------------------------
// one tap lane: words whose tag equals key are copied to the mirror port
// every word continues downstream, a match waits for mirror space
//----------------------------------------------------------------------
`timescale 1ns/1ps

module condition_mirror import tap_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  tag_t     key,       // static while the tap is idle
    stream_if.sink   up,
    stream_if.source dn,
    stream_if.source mir        // copy of each matching word
);

    stream_if #(.T(word_t)) in_post  (.clock(clock), .rst_n(rst_n));   // after input stage
    stream_if #(.T(word_t)) out_pre  (.clock(clock), .rst_n(rst_n));   // into main output stage
    stream_if #(.T(word_t)) mir_pre  (.clock(clock), .rst_n(rst_n));   // into mirror stage

    logic match;        // tag of the waiting word equals this lane's key
    logic gate_open;    // the waiting word may leave the input stage

    // ------------------------------------------------------------------
    // input stage
    // ------------------------------------------------------------------
    pipe_stage #(.T(word_t)) in_stage_i (
        .clock (clock),
        .rst_n (rst_n),
        .up    (up),
        .dn    (in_post)
    );

    // ------------------------------------------------------------------
    // gate
    // ------------------------------------------------------------------
    assign match = (tag_of(in_post.data) == key);

    // a mismatch only needs the main stage, a match needs both stages
    // so the word and its copy leave together
    assign gate_open = out_pre.ready && (!match || mir_pre.ready);

    assign in_post.ready = gate_open;

    assign out_pre.valid = in_post.valid && (!match || mir_pre.ready);
    assign out_pre.data  = in_post.data;

    assign mir_pre.valid = in_post.valid && match && out_pre.ready;
    assign mir_pre.data  = in_post.data;   // the full word goes to the mirror

    // ------------------------------------------------------------------
    // output stages
    // ------------------------------------------------------------------
    pipe_stage #(.T(word_t)) out_stage_i (
        .clock (clock),
        .rst_n (rst_n),
        .up    (out_pre),
        .dn    (dn)
    );

    // a full mirror stage drops mir_pre.ready and so holds matching words
    pipe_stage #(.T(word_t)) mir_stage_i (
        .clock (clock),
        .rst_n (rst_n),
        .up    (mir_pre),
        .dn    (mir)
    );

endmodule

// ==== logic/mirror_merge.sv ====
//----------------------------------------------------------------------
// round-robin merge of the lane mirror streams into one record stream
// each record carries the index of the lane that produced it
//----------------------------------------------------------------------
`timescale 1ns/1ps

`include "tap_settings.svh"

module mirror_merge import tap_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    stream_if.sink   lanes [`TAP_NUM_LANES],
    stream_if.source mir                        // carries mirror_rec_t
);

    localparam int NL = `TAP_NUM_LANES;

    stream_if #(.T(mirror_rec_t)) rec_pre (.clock(clock), .rst_n(rst_n));

    logic [NL-1:0] lane_valid;
    word_t         lane_data [NL];
    lane_idx_t     ptr_r;           // lane with top priority next
    lane_idx_t     rr_idx;          // first valid lane at or after ptr_r
    logic          rr_found;
    logic          lock_r;          // an offered grant is waiting for ready
    lane_idx_t     lock_idx_r;
    lane_idx_t     sel_idx;
    logic          rec_fire;

    // flatten the interface array so lanes can be picked by a variable index
    for (genvar g = 0; g < NL; g++) begin : g_lane
        assign lane_valid[g] = lanes[g].valid;
        assign lane_data[g]  = lanes[g].data;
        assign lanes[g].ready = rec_fire && (sel_idx == lane_idx_t'(g));
    end

    // search from the pointer, wrapping around the lanes
    always_comb begin : rr_search
        lane_idx_t cand;
        rr_found = 1'b0;
        rr_idx   = ptr_r;
        cand     = ptr_r;
        for (int k = 0; k < NL; k++) begin
            cand = lane_idx_t'((int'(ptr_r) + k) % NL);
            if (!rr_found && lane_valid[cand]) begin
                rr_found = 1'b1;
                rr_idx   = cand;
            end
        end
    end

    // a stalled offer keeps its lane so the record stays stable
    assign sel_idx       = lock_r ? lock_idx_r : rr_idx;
    assign rec_pre.valid = lock_r || rr_found;
    assign rec_pre.data  = '{lane: sel_idx, word: lane_data[sel_idx]};
    assign rec_fire      = rec_pre.valid && rec_pre.ready;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ptr_r      <= '0;
            lock_r     <= 1'b0;
            lock_idx_r <= '0;
        end else if (rec_fire) begin
            ptr_r  <= lane_idx_t'((int'(sel_idx) + 1) % NL);    // winner drops to last
            lock_r <= 1'b0;
        end else if (rec_pre.valid) begin
            lock_r     <= 1'b1;
            lock_idx_r <= sel_idx;
        end
    end

    // registered output toward the mir_ ports
    pipe_stage #(.T(mirror_rec_t)) out_stage_i (
        .clock (clock),
        .rst_n (rst_n),
        .up    (rec_pre),
        .dn    (mir)
    );

endmodule

// ==== logic/stream_tap_top.sv ====
//----------------------------------------------------------------------
// stream tap top level with plain ports
// ingress stage, a chain of condition-mirror lanes and the mirror merge
// keys on tap_keys may change only while no words are in flight
//----------------------------------------------------------------------
`timescale 1ns/1ps

`include "tap_settings.svh"

module stream_tap_top import tap_pkg::*; (
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  logic [`TAP_NUM_LANES*$bits(tag_t)-1:0]    tap_keys,   // lane k key at byte k

    input  logic                                      in_valid,
    output logic                                      in_ready,
    input  word_t                                     in_data,

    output logic                                      out_valid,
    input  logic                                      out_ready,
    output word_t                                     out_data,

    output logic                                      mir_valid,
    input  logic                                      mir_ready,
    output lane_idx_t                                 mir_lane,
    output word_t                                     mir_data
);

    localparam int NL = `TAP_NUM_LANES;
    localparam int TW = $bits(tag_t);

    // ------------------------------------------------------------------
    // internal links
    // ------------------------------------------------------------------
    stream_if #(.T(word_t))       in_if             (.clock(clock), .rst_n(rst_n));
    stream_if #(.T(word_t))       chain   [NL+1]    (.clock(clock), .rst_n(rst_n));  // lane k sits between k and k+1
    stream_if #(.T(word_t))       lane_mir [NL]     (.clock(clock), .rst_n(rst_n));
    stream_if #(.T(mirror_rec_t)) mir_if            (.clock(clock), .rst_n(rst_n));

    assign in_if.valid = in_valid;
    assign in_if.data  = in_data;
    assign in_ready    = in_if.ready;

    // ------------------------------------------------------------------
    // ingress
    // ------------------------------------------------------------------
    pipe_stage #(.T(word_t)) ingress_i (
        .clock (clock),
        .rst_n (rst_n),
        .up    (in_if),
        .dn    (chain[0])
    );

    // ------------------------------------------------------------------
    // lane chain, two cycles per lane on the main path
    // ------------------------------------------------------------------
    for (genvar k = 0; k < NL; k++) begin : g_lanes
        condition_mirror lane_i (
            .clock (clock),
            .rst_n (rst_n),
            .key   (tap_keys[k*TW +: TW]),
            .up    (chain[k]),
            .dn    (chain[k+1]),
            .mir   (lane_mir[k])
        );
    end

    // last lane drives the main output
    assign out_valid       = chain[NL].valid;
    assign out_data        = chain[NL].data;
    assign chain[NL].ready = out_ready;

    // ------------------------------------------------------------------
    // mirror drain
    // ------------------------------------------------------------------
    mirror_merge merge_i (
        .clock (clock),
        .rst_n (rst_n),
        .lanes (lane_mir),
        .mir   (mir_if)
    );

    assign mir_valid    = mir_if.valid;
    assign mir_lane     = mir_if.data.lane;   // split the record back into ports
    assign mir_data     = mir_if.data.word;
    assign mir_if.ready = mir_ready;

endmodule

// ==== verification/stream_tap_assertions.sv ====
//----------------------------------------------------------------------
// concurrent handshake and reset checks on the stream tap ports
// attached to stream_tap_top with bind from the testbench
//----------------------------------------------------------------------
`timescale 1ns/1ps

module stream_tap_assertions import tap_pkg::*; (
    input logic      clock,
    input logic      rst_n,
    input logic      in_valid,
    input logic      in_ready,
    input word_t     in_data,
    input logic      out_valid,
    input logic      out_ready,
    input word_t     out_data,
    input logic      mir_valid,
    input logic      mir_ready,
    input lane_idx_t mir_lane,
    input word_t     mir_data
);

    int fail_cnt = 0;   // read by the testbench at the end of the run

    // a stalled input beat stays offered and unchanged
    a_in_hold: assert property (@(posedge clock) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else begin fail_cnt++; $error("in_ beat dropped or changed while stalled"); end

    // the main output keeps its beat until out_ready
    a_out_hold: assert property (@(posedge clock) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else begin fail_cnt++; $error("out_ beat dropped or changed while stalled"); end

    // same rule on the merged mirror output, lane index included
    a_mir_hold: assert property (@(posedge clock) disable iff (!rst_n)
        mir_valid && !mir_ready |=> mir_valid && $stable(mir_lane) && $stable(mir_data))
        else begin fail_cnt++; $error("mir_ record dropped or changed while stalled"); end

    // a reset cycle leaves every valid and the input ready low
    a_reset_quiet: assert property (@(posedge clock)
        !rst_n |=> !out_valid && !mir_valid && !in_ready)
        else begin fail_cnt++; $error("valid or ready high after a reset cycle"); end

    // in_ready only falls when the ingress skid caught a beat the cycle before
    a_in_ready_skid: assert property (@(posedge clock) disable iff (!rst_n)
        $fell(in_ready) |-> $past(in_valid))
        else begin fail_cnt++; $error("in_ready fell with no beat arriving"); end

endmodule

// ==== verification/stream_tap_tb.sv ====
//----------------------------------------------------------------------
// directed testbench for the stream tap
// a reference model builds expected out_ words and per-lane mirror words
// from every accepted input beat, monitors compare at the falling edge
//----------------------------------------------------------------------
`timescale 1ns/1ps

`include "tap_settings.svh"

module stream_tap_tb import tap_pkg::*; ;

    localparam int NL          = `TAP_NUM_LANES;
    localparam int TW          = $bits(tag_t);
    localparam int TOTAL_WORDS = 16 + 16 + 12 + 40 + 24;   // sum over all tests
    localparam int LIMIT       = TOTAL_WORDS * 20 + 200;   // cycles before the watchdog fires

    logic             clock = 1'b0;
    logic             rst_n;
    logic [NL*TW-1:0] tap_keys;
    logic             in_valid;
    logic             in_ready;
    word_t            in_data;
    logic             out_valid;
    logic             out_ready;
    word_t            out_data;
    logic             mir_valid;
    logic             mir_ready;
    lane_idx_t        mir_lane;
    word_t            mir_data;

    word_t       exp_out [$];           // expected main output in order
    word_t       exp_mir [NL][$];       // expected mirror words per lane
    mirror_rec_t mon_rec;
    integer      seed = 32'h81;
    logic [31:0] rnd;
    logic        out_rand = 1'b0;       // out_ready follows $random while set
    int          cycle_cnt = 0;
    int          check_cnt = 0;
    int          err_cnt = 0;
    int          sent_cnt = 0;
    int          out_cnt = 0;
    int          mir_cnt = 0;
    int          exp_mir_total = 0;

    always #4 clock = ~clock;           // 8 ns period

    stream_tap_top stream_tap_top_i (.*);

    bind stream_tap_top stream_tap_assertions assert_i (
        .clock(clock), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready), .in_data(in_data),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .mir_valid(mir_valid), .mir_ready(mir_ready),
        .mir_lane(mir_lane), .mir_data(mir_data)
    );

    // ------------------------------------------------------------------
    // compare tasks and reference model
    // ------------------------------------------------------------------
    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        check_cnt++;
        if (got != exp) begin
            err_cnt++;
            $display("** Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // the lane field picks the queue, so order is only checked within a lane
    task automatic check_rec(input mirror_rec_t got);
        mirror_rec_t exp;
        check_cnt++;
        if (exp_mir[got.lane].size() == 0) begin
            err_cnt++;
            $display("mirror record from lane %0d at %0t ns when none was expected",
                     got.lane, $time);
        end else begin
            exp.lane = got.lane;
            exp.word = exp_mir[got.lane].pop_front();
            if (got !== exp) begin
                err_cnt++;
                $display("** Error at %0t ns: mir_data got %h expected %h",
                         $time, got, exp);
            end
        end
    endtask

    // every accepted word goes out once, plus once per lane whose key matches
    task automatic model_accept(input word_t w);
        tag_t t;
        t = w[`TAP_TAG_H:`TAP_TAG_L];
        exp_out.push_back(w);
        for (int k = 0; k < NL; k++) begin
            if (tap_keys[k*TW +: TW] == t) begin
                exp_mir[k].push_back(w);
                exp_mir_total++;
            end
        end
    endtask

    function automatic bit mirrors_empty();
        for (int k = 0; k < NL; k++) begin
            if (exp_mir[k].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // handshakes are sampled at the falling edge where every signal is settled
    always @(negedge clock) begin
        if (rst_n) begin
            if (in_valid && in_ready) model_accept(in_data);
            if (out_valid && out_ready) begin
                out_cnt++;
                if (exp_out.size() == 0) begin
                    err_cnt++;
                    $display("word %h on out_data at %0t ns when none was expected",
                             out_data, $time);
                end else begin
                    check_word("out_data", out_data, exp_out.pop_front());
                end
            end
            if (mir_valid && mir_ready) begin
                mir_cnt++;
                mon_rec.lane = mir_lane;
                mon_rec.word = mir_data;
                check_rec(mon_rec);
            end
        end
    end

    always @(posedge clock) begin
        #1;
        if (out_rand) begin
            rnd = $random(seed);
            out_ready = rnd[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // drivers
    // ------------------------------------------------------------------
    task automatic apply_reset();
        rst_n = 1'b0;
        @(posedge clock);
        @(negedge clock);
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("mir_valid", mir_valid, 1'b0);
        @(posedge clock);
        #1;
        rst_n = 1'b1;
        @(negedge clock);                           // first cycle out of reset
        check_bit("out_valid", out_valid, 1'b0);
        check_bit("mir_valid", mir_valid, 1'b0);
        check_bit("in_ready", in_ready, 1'b0);
        @(negedge clock);
        check_bit("in_ready", in_ready, 1'b1);      // registered ready is up now
        @(posedge clock);
        #1;
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_word(input word_t w);
        in_valid = 1'b1;
        in_data  = w;
        @(negedge clock);
        while (!in_ready) @(negedge clock);
        @(posedge clock);
        #1;
        in_valid = 1'b0;
        sent_cnt++;
    endtask

    task automatic wait_idle();
        @(negedge clock);
        while (exp_out.size() != 0 || !mirrors_empty()) @(negedge clock);
        repeat (10) @(negedge clock);               // room for any stray beat
        @(posedge clock);
        #1;
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic test_no_match();
        tap_keys = {8'h13, 8'h12, 8'h11, 8'h10};
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            send_word({tag_t'(8'h40 + i), rnd[23:0]});
        end
        wait_idle();
    endtask

    task automatic test_lane_match();
        tap_keys = {8'h13, 8'h12, 8'h11, 8'h10};
        for (int i = 0; i < 16; i++) begin
            rnd = $random(seed);
            if (i % 5 == 4) send_word({8'h77, rnd[23:0]});
            else send_word({tag_t'(8'h10 + i % 5), rnd[23:0]});
        end
        wait_idle();
    endtask

    task automatic test_shared_key();
        tap_keys = {8'h55, 8'h22, 8'h55, 8'h21};   // lanes 1 and 3 share a key
        for (int i = 0; i < 12; i++) begin
            rnd = $random(seed);
            if (i % 2 == 0) send_word({8'h55, rnd[23:0]});
            else send_word({(i % 4 == 1) ? 8'h21 : 8'h30, rnd[23:0]});
        end
        wait_idle();
    endtask

    task automatic test_out_stall();
        tap_keys = {8'h13, 8'h12, 8'h11, 8'h10};
        out_rand = 1'b1;
        for (int i = 0; i < 40; i++) begin
            rnd = $random(seed);
            send_word({rnd[26] ? {6'h04, rnd[25:24]} : {1'b1, rnd[30:24]}, rnd[23:0]});
        end
        wait_idle();
        out_rand = 1'b0;
    endtask

    // the mirror side backs up into the chain, then drains after release
    task automatic test_mir_stall();
        tap_keys  = {8'hA3, 8'hA2, 8'hA1, 8'hA0};
        mir_ready = 1'b0;
        fork
            for (int i = 0; i < 24; i++) begin
                rnd = $random(seed);
                send_word({tag_t'(8'hA0 + i % 4), rnd[23:0]});
            end
            begin
                repeat (60) @(posedge clock);
                #1;
                mir_ready = 1'b1;
            end
        join
        wait_idle();
        check_count("out word count", out_cnt, sent_cnt);
        check_count("mirror record count", mir_cnt, exp_mir_total);
    endtask

    // ------------------------------------------------------------------
    // run control
    // ------------------------------------------------------------------
    initial begin : watchdog
        while (cycle_cnt < LIMIT) begin
            @(posedge clock);
            cycle_cnt++;
        end
        $display("run stopped after %0d cycles with words still in flight", LIMIT);
        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b1;
        mir_ready = 1'b1;
        tap_keys  = {8'h13, 8'h12, 8'h11, 8'h10};
        apply_reset();
        test_no_match();
        test_lane_match();
        test_shared_key();
        test_out_stall();
        test_mir_stall();
        err_cnt += stream_tap_top_i.assert_i.fail_cnt;   // bound assertion failures
        $display("checks %0d, errors %0d, words %0d, mirror records %0d",
                 check_cnt, err_cnt, sent_cnt, mir_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+logic
logic/tap_pkg.sv
logic/stream_if.sv
logic/pipe_stage.sv
logic/condition_mirror.sv
logic/mirror_merge.sv
logic/stream_tap_top.sv
verification/stream_tap_assertions.sv
verification/stream_tap_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := stream_tap_tb
FILELIST  := vlog.f
OBJDIR    := obj_dir
FLAGS     := --timing --assert --timescale 1ns/1ps
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Simulation completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
